//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// One bus word, also the width of every general register
`define DATA_WIDTH 32

// General register count, R0 through R15
`define REG_COUNT 16

// Word-addressed RAM size
`define RAM_DEPTH 512

// Low MAR bits that index the RAM
`define ADDR_WIDTH 9

`endif

//--- cpuPkg.sv
package cpuPkg;

    // ALU operation codes, shared with the instruction opcode field
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opRor  = 5'b00111,
        opRol  = 5'b01000,
        opShr  = 5'b01001,
        opShra = 5'b01010,
        opShl  = 5'b01011,
        opMul  = 5'b10000,
        opNeg  = 5'b10001,
        opNot  = 5'b10010
    } aluOp_t;

    // One instruction word seen as three-register or register-plus-constant form
    typedef union packed {
        struct packed {
            logic [4:0]  opcode;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [3:0]  rc;
            logic [14:0] unused;
        } rForm;
        struct packed {
            logic [4:0]  opcode;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [18:0] constant;
        } iForm;
    } instruction_t;

endpackage

//--- registerFile.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module registerFile (
    input  logic                   Clock,
    input  logic                   rst,
    input  logic                   writeEnable,
    input  logic [3:0]             writeIndex,
    input  logic [3:0]             readIndex,
    input  logic                   zeroR0,
    input  logic [`DATA_WIDTH-1:0] writeData,
    output logic [`DATA_WIDTH-1:0] readData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeIndex] <= writeData;
        end
    end

    // Base-address reads treat R0 as a constant zero
    assign readData = (zeroR0 && readIndex == 4'd0) ? '0 : regs[readIndex];

endmodule

//--- selectEncode.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module selectEncode
    import cpuPkg::*;
(
    input  instruction_t           instruction,
    input  logic                   grA,
    input  logic                   grB,
    input  logic                   grC,
    output logic [3:0]             writeIndex,
    output logic [3:0]             readIndex,
    output logic [`DATA_WIDTH-1:0] constant
);

    logic [3:0] selected;

    // Grant priority is A, then B, then C
    always_comb begin
        if (grA) begin
            selected = instruction.rForm.ra;
        end else if (grB) begin
            selected = instruction.rForm.rb;
        end else if (grC) begin
            selected = instruction.rForm.rc;
        end else begin
            selected = 4'd0;
        end
    end

    // Read and write share one selected field
    assign writeIndex = selected;
    assign readIndex  = selected;

    // 19-bit immediate, sign extended to a full word
    assign constant = {{(`DATA_WIDTH - 19){instruction.iForm.constant[18]}},
                       instruction.iForm.constant};

endmodule

//--- alu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module alu
    import cpuPkg::*;
(
    input  aluOp_t                   opcode,
    input  logic [`DATA_WIDTH-1:0]   yValue,
    input  logic [`DATA_WIDTH-1:0]   busValue,
    output logic [2*`DATA_WIDTH-1:0] result
);

    logic [4:0]                   shiftAmount;
    logic [2*`DATA_WIDTH-1:0]     rorWide;
    logic [2*`DATA_WIDTH-1:0]     rolWide;
    logic signed [2*`DATA_WIDTH-1:0] product;
    logic [`DATA_WIDTH-1:0]       lowWord;

    assign shiftAmount = busValue[4:0];

    // Rotates come out of a doubled copy of Y
    assign rorWide = {yValue, yValue} >> shiftAmount;
    assign rolWide = {yValue, yValue} << shiftAmount;

    // Full signed product, both operands sign extended first
    assign product = (2*`DATA_WIDTH)'($signed(yValue)) * (2*`DATA_WIDTH)'($signed(busValue));

    always_comb begin
        case (opcode)
            opAdd:   lowWord = yValue + busValue;
            opSub:   lowWord = yValue - busValue;
            opAnd:   lowWord = yValue & busValue;
            opOr:    lowWord = yValue | busValue;
            opShr:   lowWord = yValue >> shiftAmount;
            opShra:  lowWord = $signed(yValue) >>> shiftAmount;
            opShl:   lowWord = yValue << shiftAmount;
            opRor:   lowWord = rorWide[`DATA_WIDTH-1:0];
            opRol:   lowWord = rolWide[2*`DATA_WIDTH-1:`DATA_WIDTH];
            opMul:   lowWord = product[`DATA_WIDTH-1:0];
            // Unary ops ignore Y
            opNeg:   lowWord = -busValue;
            opNot:   lowWord = ~busValue;
            default: lowWord = '0;
        endcase
    end

    // Only the multiply fills the upper word on its own
    assign result = (opcode == opMul) ? product
                  : {{`DATA_WIDTH{lowWord[`DATA_WIDTH-1]}}, lowWord};

endmodule

//--- memoryInterface.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module memoryInterface (
    input  logic                   Clock,
    input  logic                   rst,
    input  logic                   marIn,
    input  logic                   mdrIn,
    input  logic                   read,
    input  logic                   mdataLoad,
    input  logic                   write,
    input  logic [`DATA_WIDTH-1:0] busValue,
    input  logic [`DATA_WIDTH-1:0] mdataIn,
    output logic [`DATA_WIDTH-1:0] mdrValue
);

    logic [`DATA_WIDTH-1:0] marReg;
    logic [`DATA_WIDTH-1:0] mdrReg;
    logic [`DATA_WIDTH-1:0] mdrNext;
    logic [`DATA_WIDTH-1:0] ramWord;
    logic [`ADDR_WIDTH-1:0] ramAddr;
    logic [`DATA_WIDTH-1:0] ram [`RAM_DEPTH];

    assign ramAddr = marReg[`ADDR_WIDTH-1:0];
    assign ramWord = ram[ramAddr];

    // MDR source: RAM first, then external data, else the bus
    always_comb begin
        if (read) begin
            mdrNext = ramWord;
        end else if (mdataLoad) begin
            mdrNext = mdataIn;
        end else begin
            mdrNext = busValue;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            marReg <= '0;
            mdrReg <= '0;
        end else begin
            if (marIn) begin
                marReg <= busValue;
            end
            if (mdrIn) begin
                mdrReg <= mdrNext;
            end
        end
    end

    // Store path writes the current MDR
    always_ff @(posedge Clock) begin
        if (write) begin
            ram[ramAddr] <= mdrReg;
        end
    end

    assign mdrValue = mdrReg;

endmodule

//--- datapath.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapath
    import cpuPkg::*;
(
    input  logic                   Clock,
    input  logic                   rst,
    input  logic                   marIn,
    input  logic                   mdrIn,
    input  logic                   zIn,
    input  logic                   pcIn,
    input  logic                   irIn,
    input  logic                   yIn,
    input  logic                   hiIn,
    input  logic                   loIn,
    input  logic                   regIn,
    input  logic                   read,
    input  logic                   mdataLoad,
    input  logic                   write,
    input  logic                   incPc,
    input  aluOp_t                 opcode,
    input  logic [`DATA_WIDTH-1:0] mdataIn,
    input  logic                   grA,
    input  logic                   grB,
    input  logic                   grC,
    input  logic                   regOut,
    input  logic                   baOut,
    input  logic                   pcOut,
    input  logic                   mdrOut,
    input  logic                   zHighOut,
    input  logic                   zLowOut,
    input  logic                   hiOut,
    input  logic                   loOut,
    input  logic                   cOut,
    output logic [`DATA_WIDTH-1:0] busValue
);

    logic [`DATA_WIDTH-1:0]   pcReg;
    logic [`DATA_WIDTH-1:0]   yReg;
    logic [`DATA_WIDTH-1:0]   hiReg;
    logic [`DATA_WIDTH-1:0]   loReg;
    logic [2*`DATA_WIDTH-1:0] zReg;
    instruction_t             irReg;

    logic [`DATA_WIDTH-1:0]   regReadData;
    logic [`DATA_WIDTH-1:0]   mdrValue;
    logic [`DATA_WIDTH-1:0]   constant;
    logic [2*`DATA_WIDTH-1:0] aluResult;
    logic [3:0]               writeIndex;
    logic [3:0]               readIndex;

    // Prioritized bus source, zero when nothing drives
    always_comb begin
        if (regOut || baOut) begin
            busValue = regReadData;
        end else if (pcOut) begin
            busValue = pcReg;
        end else if (mdrOut) begin
            busValue = mdrValue;
        end else if (zHighOut) begin
            busValue = zReg[2*`DATA_WIDTH-1:`DATA_WIDTH];
        end else if (zLowOut) begin
            busValue = zReg[`DATA_WIDTH-1:0];
        end else if (hiOut) begin
            busValue = hiReg;
        end else if (loOut) begin
            busValue = loReg;
        end else if (cOut) begin
            busValue = constant;
        end else begin
            busValue = '0;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            pcReg <= '0;
            irReg <= '0;
            yReg  <= '0;
            zReg  <= '0;
            hiReg <= '0;
            loReg <= '0;
        end else begin
            // Increment wins over a bus load of PC
            if (pcIn && incPc) begin
                pcReg <= pcReg + 1'b1;
            end else if (pcIn) begin
                pcReg <= busValue;
            end
            if (irIn) irReg <= busValue;
            if (yIn)  yReg  <= busValue;
            if (zIn)  zReg  <= aluResult;
            if (hiIn) hiReg <= busValue;
            if (loIn) loReg <= busValue;
        end
    end

    selectEncode selector (
        .instruction (irReg),
        .grA         (grA),
        .grB         (grB),
        .grC         (grC),
        .writeIndex  (writeIndex),
        .readIndex   (readIndex),
        .constant    (constant)
    );

    registerFile regs (
        .Clock       (Clock),
        .rst         (rst),
        .writeEnable (regIn),
        .writeIndex  (writeIndex),
        .readIndex   (readIndex),
        .zeroR0      (baOut),
        .writeData   (busValue),
        .readData    (regReadData)
    );

    alu aluUnit (
        .opcode      (opcode),
        .yValue      (yReg),
        .busValue    (busValue),
        .result      (aluResult)
    );

    memoryInterface memory (
        .Clock       (Clock),
        .rst         (rst),
        .marIn       (marIn),
        .mdrIn       (mdrIn),
        .read        (read),
        .mdataLoad   (mdataLoad),
        .write       (write),
        .busValue    (busValue),
        .mdataIn     (mdataIn),
        .mdrValue    (mdrValue)
    );

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic Clock,
    output logic rst
);

    // 20 ns period
    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    // Reset held over three rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0;
    end

endmodule

//--- datapathTb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapathTb
    import cpuPkg::*;
();

    localparam int maxRows = 256;

    // One bit per control strobe in a table row
    localparam logic [31:0] marInBit    = 32'h0000_0001;
    localparam logic [31:0] mdrInBit    = 32'h0000_0002;
    localparam logic [31:0] zInBit      = 32'h0000_0004;
    localparam logic [31:0] pcInBit     = 32'h0000_0008;
    localparam logic [31:0] irInBit     = 32'h0000_0010;
    localparam logic [31:0] yInBit      = 32'h0000_0020;
    localparam logic [31:0] hiInBit     = 32'h0000_0040;
    localparam logic [31:0] loInBit     = 32'h0000_0080;
    localparam logic [31:0] regInBit    = 32'h0000_0100;
    localparam logic [31:0] readBit     = 32'h0000_0200;
    localparam logic [31:0] mdataBit    = 32'h0000_0400;
    localparam logic [31:0] writeBit    = 32'h0000_0800;
    localparam logic [31:0] incPcBit    = 32'h0000_1000;
    localparam logic [31:0] grABit      = 32'h0000_2000;
    localparam logic [31:0] grBBit      = 32'h0000_4000;
    localparam logic [31:0] grCBit      = 32'h0000_8000;
    localparam logic [31:0] regOutBit   = 32'h0001_0000;
    localparam logic [31:0] baOutBit    = 32'h0002_0000;
    localparam logic [31:0] pcOutBit    = 32'h0004_0000;
    localparam logic [31:0] mdrOutBit   = 32'h0008_0000;
    localparam logic [31:0] zHighOutBit = 32'h0010_0000;
    localparam logic [31:0] zLowOutBit  = 32'h0020_0000;
    localparam logic [31:0] hiOutBit    = 32'h0040_0000;
    localparam logic [31:0] loOutBit    = 32'h0080_0000;
    localparam logic [31:0] cOutBit     = 32'h0100_0000;

    logic                   Clock;
    logic                   rst;
    logic [31:0]            ctrlWord;
    aluOp_t                 opDrive;
    logic [`DATA_WIDTH-1:0] dataDrive;
    logic [`DATA_WIDTH-1:0] busValue;

    logic [31:0] ctrlTable [maxRows];
    aluOp_t      opTable [maxRows];
    logic [31:0] dataTable [maxRows];
    logic        checkTable [maxRows];
    logic [31:0] expectTable [maxRows];
    int          rowCount;
    int          checkCount;
    int          errorCount;
    int          cycleCount;
    int          cycleLimit;

    // Software model state
    logic [31:0] modelRegs [16];
    logic [31:0] modelY;
    logic [63:0] modelZ;

    tbClock clockGen (
        .Clock (Clock),
        .rst   (rst)
    );

    datapath DUT (
        .Clock     (Clock),
        .rst       (rst),
        .marIn     (|(ctrlWord & marInBit)),
        .mdrIn     (|(ctrlWord & mdrInBit)),
        .zIn       (|(ctrlWord & zInBit)),
        .pcIn      (|(ctrlWord & pcInBit)),
        .irIn      (|(ctrlWord & irInBit)),
        .yIn       (|(ctrlWord & yInBit)),
        .hiIn      (|(ctrlWord & hiInBit)),
        .loIn      (|(ctrlWord & loInBit)),
        .regIn     (|(ctrlWord & regInBit)),
        .read      (|(ctrlWord & readBit)),
        .mdataLoad (|(ctrlWord & mdataBit)),
        .write     (|(ctrlWord & writeBit)),
        .incPc     (|(ctrlWord & incPcBit)),
        .opcode    (opDrive),
        .mdataIn   (dataDrive),
        .grA       (|(ctrlWord & grABit)),
        .grB       (|(ctrlWord & grBBit)),
        .grC       (|(ctrlWord & grCBit)),
        .regOut    (|(ctrlWord & regOutBit)),
        .baOut     (|(ctrlWord & baOutBit)),
        .pcOut     (|(ctrlWord & pcOutBit)),
        .mdrOut    (|(ctrlWord & mdrOutBit)),
        .zHighOut  (|(ctrlWord & zHighOutBit)),
        .zLowOut   (|(ctrlWord & zLowOutBit)),
        .hiOut     (|(ctrlWord & hiOutBit)),
        .loOut     (|(ctrlWord & loOutBit)),
        .cOut      (|(ctrlWord & cOutBit)),
        .busValue  (busValue)
    );

    // Reference ALU from the operation rules
    function automatic logic [63:0] aluModel(input aluOp_t op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] low;
        logic [63:0] full;
        int unsigned n;
        n = {27'd0, b[4:0]};
        case (op)
            opAdd:   low = a + b;
            opSub:   low = a + ~b + 32'd1;
            opAnd:   low = a & b;
            opOr:    low = a | b;
            opShr:   low = a >> n;
            opShra:  low = 32'($signed(a) >>> n);
            opShl:   low = a << n;
            // Rotate as two opposite shifts merged
            opRor:   low = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
            opRol:   low = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
            opNeg:   low = 32'd0 - b;
            opNot:   low = ~b;
            default: low = '0;
        endcase
        if (op == opMul) begin
            full = 64'(longint'($signed(a)) * longint'($signed(b)));
        end else begin
            full = {{32{low[31]}}, low};
        end
        return full;
    endfunction

    function automatic instruction_t rWord(input logic [3:0] ra, input logic [3:0] rb,
                                           input logic [3:0] rc);
        instruction_t word;
        word = '0;
        word.rForm.ra = ra;
        word.rForm.rb = rb;
        word.rForm.rc = rc;
        return word;
    endfunction

    function automatic instruction_t iWord(input logic [3:0] ra, input logic [3:0] rb,
                                           input logic [18:0] offset);
        instruction_t word;
        word = '0;
        word.iForm.ra = ra;
        word.iForm.rb = rb;
        word.iForm.constant = offset;
        return word;
    endfunction

    task automatic appendRow(input logic [31:0] ctrl, input aluOp_t op,
                             input logic [31:0] data, input logic check,
                             input logic [31:0] expected);
        ctrlTable[rowCount]   = ctrl;
        opTable[rowCount]     = op;
        dataTable[rowCount]   = data;
        checkTable[rowCount]  = check;
        expectTable[rowCount] = expected;
        rowCount++;
    endtask

    task automatic step(input logic [31:0] ctrl, input logic [31:0] data);
        appendRow(ctrl, opAdd, data, 1'b0, '0);
    endtask

    task automatic expectBus(input logic [31:0] ctrl, input logic [31:0] expected);
        appendRow(ctrl, opAdd, '0, 1'b1, expected);
    endtask

    // Instruction word passes through MDR into IR
    task automatic loadIr(input instruction_t word);
        step(mdataBit | mdrInBit, word);
        step(mdrOutBit | irInBit, '0);
    endtask

    task automatic loadReg(input logic [3:0] index, input logic [31:0] value);
        loadIr(rWord(index, 4'd0, 4'd0));
        step(mdataBit | mdrInBit, value);
        step(mdrOutBit | regInBit | grABit, '0);
        modelRegs[index] = value;
    endtask

    task automatic readBackReg(input logic [3:0] index);
        loadIr(rWord(index, 4'd0, 4'd0));
        expectBus(regOutBit | grABit, modelRegs[index]);
    endtask

    task automatic storeWord(input logic [31:0] addr, input logic [31:0] value);
        step(mdataBit | mdrInBit, addr);
        step(mdrOutBit | marInBit, '0);
        step(mdataBit | mdrInBit, value);
        step(writeBit, '0);
    endtask

    // Y from Ra, then Rb through the ALU into Z, then both Z halves on the bus
    task automatic aluSequence(input aluOp_t op);
        modelY = modelRegs[2];
        step(regOutBit | grABit | yInBit, '0);
        modelZ = aluModel(op, modelY, modelRegs[3]);
        appendRow(regOutBit | grBBit | zInBit, op, '0, 1'b0, '0);
        expectBus(zLowOutBit, modelZ[31:0]);
        expectBus(zHighOutBit, modelZ[63:32]);
    endtask

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        aluOp_t      opList [12];
        logic [31:0] sourceList [9];
        logic [31:0] base;
        logic [31:0] addr;
        logic [31:0] value;
        logic [31:0] displacement;
        logic [18:0] offset;
        logic [3:0]  rb;
        ctrlWord   = '0;
        opDrive    = opAdd;
        dataDrive  = '0;
        rowCount   = 0;
        checkCount = 0;
        errorCount = 0;
        cycleLimit = 0;
        void'($urandom(32'h74c0));
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end

        // Every bus source reads zero after reset
        sourceList = '{regOutBit | grABit, baOutBit | grABit, pcOutBit, mdrOutBit,
                       zHighOutBit, zLowOutBit, hiOutBit, loOutBit, cOutBit};
        foreach (sourceList[i]) begin
            expectBus(sourceList[i], '0);
        end

        // R0 gets a nonzero value so the base-address path must mask it
        loadReg(4'd0, $urandom() | 32'd1);
        loadReg(4'd2, $urandom());
        loadReg(4'd3, $urandom());
        loadReg(4'd1, $urandom());
        readBackReg(4'd2);
        readBackReg(4'd3);
        readBackReg(4'd1);

        loadIr(rWord(4'd2, 4'd3, 4'd1));
        expectBus(regOutBit | grCBit, modelRegs[1]);
        opList = '{opAdd, opSub, opAnd, opOr, opShr, opShra, opShl,
                   opRor, opRol, opNeg, opNot, opMul};
        foreach (opList[i]) begin
            aluSequence(opList[i]);
        end
        expectBus(zHighOutBit | hiInBit, modelZ[63:32]);
        expectBus(hiOutBit, modelZ[63:32]);
        step(zLowOutBit | loInBit, '0);
        expectBus(loOutBit, modelZ[31:0]);

        // Store then load back through the read path
        addr  = $urandom() & 32'h1FF;
        value = $urandom();
        storeWord(addr, value);
        step(mdataBit | mdrInBit, '0);
        step(readBit | mdrInBit, '0);
        expectBus(mdrOutBit, value);

        // ld with rb of 0 and a negative offset, then with R1 as base and a positive offset
        for (int k = 0; k < 2; k++) begin
            rb           = 4'(k);
            offset       = 19'($urandom());
            offset[18]   = (k == 0);
            displacement = 32'($signed(offset));
            base         = (rb == 4'd0) ? '0 : modelRegs[rb];
            addr         = base + displacement;
            value        = $urandom();
            storeWord(addr, value);
            loadIr(iWord(4'd4 + rb, rb, offset));
            expectBus(baOutBit | grBBit | yInBit, base);
            expectBus(cOutBit | zInBit, displacement);
            expectBus(zLowOutBit | marInBit, addr);
            step(readBit | mdrInBit, '0);
            step(mdrOutBit | regInBit | grABit, '0);
            modelRegs[4 + k] = value;
            readBackReg(4'd4 + rb);
        end

        // Fetch step moves PC to PC plus one
        value = $urandom();
        step(mdataBit | mdrInBit, value);
        step(mdrOutBit | pcInBit, '0);
        expectBus(pcOutBit | marInBit, value);
        step(incPcBit | pcInBit, '0);
        expectBus(pcOutBit, value + 32'd1);

        cycleLimit = rowCount + 3 + 20;
        wait (rst == 1'b0);
        for (int r = 0; r < rowCount; r++) begin
            @(negedge Clock);
            ctrlWord  = ctrlTable[r];
            opDrive   = opTable[r];
            dataDrive = dataTable[r];
            #2;
            if (checkTable[r]) begin
                checkCount++;
                if (busValue !== expectTable[r]) begin
                    errorCount++;
                    $display("ERROR row %0d: busValue expected 0x%08h, got 0x%08h",
                             r, expectTable[r], busValue);
                end
            end
        end
        @(negedge Clock);
        ctrlWord = '0;
        $display("Rows: %0d, checks: %0d, errors: %0d", rowCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
cpuPkg.sv
registerFile.sv
selectEncode.sv
alu.sv
memoryInterface.sv
datapath.sv
tbClock.sv
datapathTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the datapath testbench with Verilator, runs it and inspects the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module datapathTb -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VdatapathTb > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "Simulation run returned status $runStatus"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1
